/* ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

	localparam int XLEN     = 32;
	localparam int NUM_AR   = 32;
	localparam int AR_BITS  = 5;
	localparam int NUM_PR   = 64;
	localparam int PR_BITS  = 6;
	localparam int ROB_BITS = 4;    // Caps ROB_DEPTH at 16

	typedef logic [AR_BITS-1:0]  ar_idx_t;
	typedef logic [PR_BITS-1:0]  pr_tag_t;
	typedef logic [ROB_BITS-1:0] rob_idx_t;
	typedef logic [XLEN-1:0]     word_t;

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_XOR  = 3'd3,
		OP_ADDI = 3'd4,
		OP_MUL  = 3'd5
	} opcode_e;

	// Instruction as it enters the core
	typedef struct packed {
		opcode_e opcode;
		ar_idx_t dest;
		ar_idx_t src_a;
		ar_idx_t src_b;
		word_t   imm;
	} decoded_op_t;

	typedef struct packed {
		logic     valid;
		opcode_e  opcode;
		pr_tag_t  src_a;
		logic     src_a_rdy;
		pr_tag_t  src_b;
		logic     src_b_rdy;
		word_t    imm;
		pr_tag_t  dest;
		pr_tag_t  old_dest;    // Released at commit
		ar_idx_t  dest_ar;
		rob_idx_t rob_idx;
	} dispatch_t;

	typedef struct packed {
		logic     valid;
		opcode_e  opcode;
		pr_tag_t  src_a;
		pr_tag_t  src_b;
		word_t    imm;
		pr_tag_t  dest;
		rob_idx_t rob_idx;
	} issue_t;

	// Result broadcast
	typedef struct packed {
		logic     valid;
		pr_tag_t  tag;
		rob_idx_t rob_idx;
		word_t    value;
	} cdb_t;

endpackage

`default_nettype wire

/* rename_unit.sv */
`default_nettype none

module rename_unit (
	input  wire                       clock,
	input  wire                       arst_n,
	input  wire                       in_valid,
	input  wire ooo_pkg::decoded_op_t in_op,
	output logic                      in_ready,
	input  wire                       rob_ready,
	input  wire                       iq_ready,
	input  wire ooo_pkg::rob_idx_t    rob_tail,
	input  wire                       free_valid,
	input  wire ooo_pkg::pr_tag_t     free_tag,
	input  wire ooo_pkg::cdb_t        cdb,
	output ooo_pkg::dispatch_t        disp
);

	localparam int FL_DEPTH = ooo_pkg::NUM_PR - ooo_pkg::NUM_AR;
	localparam int FL_BITS  = $clog2(FL_DEPTH);
	localparam logic [FL_BITS:0] FL_FULL = (FL_BITS + 1)'(FL_DEPTH);

	ooo_pkg::pr_tag_t           map_q [ooo_pkg::NUM_AR];
	logic [ooo_pkg::NUM_PR-1:0] prdy_q;               // One ready bit per tag
	ooo_pkg::pr_tag_t           fl_q [FL_DEPTH];
	logic [FL_BITS-1:0]         fl_head_q;
	logic [FL_BITS-1:0]         fl_tail_q;
	logic [FL_BITS:0]           fl_count_q;

	logic             xfer;
	logic             is_imm;
	logic             rdy_a;
	logic             rdy_b;
	ooo_pkg::pr_tag_t tag_a;
	ooo_pkg::pr_tag_t tag_b;
	ooo_pkg::pr_tag_t new_tag;

	assign in_ready = (fl_count_q != '0) && rob_ready && iq_ready;
	assign xfer     = in_valid && in_ready;
	assign new_tag  = fl_q[fl_head_q];
	assign is_imm   = in_op.opcode == ooo_pkg::OP_ADDI;
	assign tag_a    = map_q[in_op.src_a];
	assign tag_b    = map_q[in_op.src_b];

	// Broadcast in this cycle counts as ready
	assign rdy_a = prdy_q[tag_a] || (cdb.valid && cdb.tag == tag_a);
	assign rdy_b = is_imm || prdy_q[tag_b] || (cdb.valid && cdb.tag == tag_b);

	always_comb begin
		disp.valid     = xfer;
		disp.opcode    = in_op.opcode;
		disp.src_a     = tag_a;
		disp.src_a_rdy = rdy_a;
		disp.src_b     = is_imm ? '0 : tag_b;
		disp.src_b_rdy = rdy_b;
		disp.imm       = in_op.imm;
		disp.dest      = new_tag;
		disp.old_dest  = map_q[in_op.dest];   // Read before the map update
		disp.dest_ar   = in_op.dest;
		disp.rob_idx   = rob_tail;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < ooo_pkg::NUM_AR; r++) begin
				map_q[r] <= ooo_pkg::pr_tag_t'(r);
			end
			for (int i = 0; i < FL_DEPTH; i++) begin
				fl_q[i] <= ooo_pkg::pr_tag_t'(ooo_pkg::NUM_AR + i);
			end
			prdy_q     <= '1;
			fl_head_q  <= '0;
			fl_tail_q  <= '0;   // Full, so tail meets head
			fl_count_q <= FL_FULL;
		end else begin
			if (cdb.valid)
				prdy_q[cdb.tag] <= 1'b1;
			if (xfer) begin
				map_q[in_op.dest] <= new_tag;
				prdy_q[new_tag]   <= 1'b0;
				fl_head_q         <= fl_head_q + 1'b1;
			end
			if (free_valid) begin
				fl_q[fl_tail_q] <= free_tag;
				fl_tail_q       <= fl_tail_q + 1'b1;
			end
			case ({free_valid, xfer})
				2'b10:   fl_count_q <= fl_count_q + 1'b1;
				2'b01:   fl_count_q <= fl_count_q - 1'b1;
				default: fl_count_q <= fl_count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

/* issue_queue.sv */
`default_nettype none

module issue_queue #(
	parameter int IQ_DEPTH = 8
) (
	input  wire                     clock,
	input  wire                     arst_n,
	input  wire ooo_pkg::dispatch_t disp,
	input  wire ooo_pkg::cdb_t      cdb,
	input  wire                     alu_ready,
	input  wire                     mul_ready,
	output logic                    iq_ready,
	output ooo_pkg::issue_t         iss
);

	localparam int IDX_BITS = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

	ooo_pkg::dispatch_t  ent_q [IQ_DEPTH];
	logic [IQ_DEPTH-1:0] valid_q;
	logic [IQ_DEPTH-1:0] rdy_a_q;
	logic [IQ_DEPTH-1:0] rdy_b_q;
	logic [IDX_BITS-1:0] age_q [IQ_DEPTH];   // Count of older valid entries

	logic [IQ_DEPTH-1:0] cand;
	logic                sel_found;
	logic [IDX_BITS-1:0] sel_idx;
	logic [IDX_BITS-1:0] wr_idx;
	logic [IDX_BITS-1:0] wr_age;

	assign iq_ready = ~&valid_q;

	always_comb begin
		for (int i = 0; i < IQ_DEPTH; i++) begin
			cand[i] = valid_q[i] && rdy_a_q[i] && rdy_b_q[i] &&
				((ent_q[i].opcode == ooo_pkg::OP_MUL) ? mul_ready : alu_ready);
		end
	end

	// Oldest candidate has the smallest age
	always_comb begin
		sel_found = 1'b0;
		sel_idx   = '0;
		for (int i = 0; i < IQ_DEPTH; i++) begin
			if (cand[i] && (!sel_found || age_q[i] < age_q[sel_idx])) begin
				sel_found = 1'b1;
				sel_idx   = IDX_BITS'(i);
			end
		end
	end

	always_comb begin
		int n_valid;
		wr_idx  = '0;
		n_valid = 0;
		for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
			if (!valid_q[i])
				wr_idx = IDX_BITS'(i);   // Lowest free slot
			else
				n_valid++;
		end
		wr_age = IDX_BITS'(n_valid - (sel_found ? 1 : 0));
	end

	always_comb begin
		iss.valid   = sel_found;
		iss.opcode  = ent_q[sel_idx].opcode;
		iss.src_a   = ent_q[sel_idx].src_a;
		iss.src_b   = ent_q[sel_idx].src_b;
		iss.imm     = ent_q[sel_idx].imm;
		iss.dest    = ent_q[sel_idx].dest;
		iss.rob_idx = ent_q[sel_idx].rob_idx;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			rdy_a_q <= '0;
			rdy_b_q <= '0;
			for (int i = 0; i < IQ_DEPTH; i++) begin
				age_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < IQ_DEPTH; i++) begin
				if (cdb.valid && ent_q[i].src_a == cdb.tag)
					rdy_a_q[i] <= 1'b1;
				if (cdb.valid && ent_q[i].src_b == cdb.tag)
					rdy_b_q[i] <= 1'b1;
				if (sel_found && valid_q[i] && age_q[i] > age_q[sel_idx])
					age_q[i] <= age_q[i] - 1'b1;   // Close the gap
			end
			if (sel_found)
				valid_q[sel_idx] <= 1'b0;
			if (disp.valid) begin
				valid_q[wr_idx] <= 1'b1;
				rdy_a_q[wr_idx] <= disp.src_a_rdy;
				rdy_b_q[wr_idx] <= disp.src_b_rdy;
				age_q[wr_idx]   <= wr_age;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (disp.valid)
			ent_q[wr_idx] <= disp;
	end

endmodule

`default_nettype wire

/* phys_regfile.sv */
`default_nettype none

module phys_regfile (
	input  wire                   clock,
	input  wire                   arst_n,
	input  wire ooo_pkg::pr_tag_t rd_a_tag,
	input  wire ooo_pkg::pr_tag_t rd_b_tag,
	output ooo_pkg::word_t        rd_a_data,
	output ooo_pkg::word_t        rd_b_data,
	input  wire ooo_pkg::cdb_t    cdb
);

	ooo_pkg::word_t regs_q [ooo_pkg::NUM_PR];

	assign rd_a_data = regs_q[rd_a_tag];
	assign rd_b_data = regs_q[rd_b_tag];

	// Unwritten registers read as zero
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ooo_pkg::NUM_PR; i++) begin
				regs_q[i] <= '0;
			end
		end else if (cdb.valid) begin
			regs_q[cdb.tag] <= cdb.value;
		end
	end

endmodule

`default_nettype wire

/* exec_unit.sv */
`default_nettype none

module exec_unit #(
	parameter int MUL_LATENCY = 3
) (
	input  wire                  clock,
	input  wire                  arst_n,
	input  wire ooo_pkg::issue_t iss,
	input  wire ooo_pkg::word_t  opa,
	input  wire ooo_pkg::word_t  opb,
	output logic                 alu_ready,
	output logic                 mul_ready,
	output ooo_pkg::cdb_t        cdb
);

	localparam int LAST = MUL_LATENCY - 1;

	logic              is_mul;
	logic              alu_go;
	logic              mul_go;
	ooo_pkg::word_t    alu_res;

	logic              alu_v_q;
	ooo_pkg::pr_tag_t  alu_tag_q;
	ooo_pkg::rob_idx_t alu_rob_q;
	ooo_pkg::word_t    alu_res_q;

	logic [MUL_LATENCY-1:0] mul_v_q;
	ooo_pkg::pr_tag_t       mul_tag_q [MUL_LATENCY];
	ooo_pkg::rob_idx_t      mul_rob_q [MUL_LATENCY];
	ooo_pkg::word_t         mul_res_q [MUL_LATENCY];

	logic [MUL_LATENCY-2:0] resv_q;   // Bit i books the CDB i+1 cycles ahead

	assign is_mul    = iss.opcode == ooo_pkg::OP_MUL;
	assign alu_go    = iss.valid && !is_mul;
	assign mul_go    = iss.valid && is_mul;
	assign alu_ready = !resv_q[0];
	assign mul_ready = 1'b1;   // Nothing issued earlier lands after a multiply

	always_comb begin
		case (iss.opcode)
			ooo_pkg::OP_ADD:  alu_res = opa + opb;
			ooo_pkg::OP_SUB:  alu_res = opa - opb;
			ooo_pkg::OP_AND:  alu_res = opa & opb;
			ooo_pkg::OP_XOR:  alu_res = opa ^ opb;
			ooo_pkg::OP_ADDI: alu_res = opa + iss.imm;
			default:          alu_res = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			alu_v_q <= 1'b0;
			mul_v_q <= '0;
			resv_q  <= '0;
		end else begin
			alu_v_q <= alu_go;
			mul_v_q <= {mul_v_q[LAST-1:0], mul_go};
			resv_q  <= (resv_q >> 1) | ((MUL_LATENCY - 1)'(mul_go) << (MUL_LATENCY - 2));
		end
	end

	always_ff @(posedge clock) begin
		if (alu_go) begin
			alu_tag_q <= iss.dest;
			alu_rob_q <= iss.rob_idx;
			alu_res_q <= alu_res;
		end
		if (mul_go) begin
			mul_tag_q[0] <= iss.dest;
			mul_rob_q[0] <= iss.rob_idx;
			mul_res_q[0] <= opa * opb;   // Low half only
		end
		for (int s = 1; s < MUL_LATENCY; s++) begin
			mul_tag_q[s] <= mul_tag_q[s-1];
			mul_rob_q[s] <= mul_rob_q[s-1];
			mul_res_q[s] <= mul_res_q[s-1];
		end
	end

	// Reservation keeps the two sources apart
	always_comb begin
		cdb.valid = alu_v_q || mul_v_q[LAST];
		if (alu_v_q) begin
			cdb.tag     = alu_tag_q;
			cdb.rob_idx = alu_rob_q;
			cdb.value   = alu_res_q;
		end else begin
			cdb.tag     = mul_tag_q[LAST];
			cdb.rob_idx = mul_rob_q[LAST];
			cdb.value   = mul_res_q[LAST];
		end
	end

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`default_nettype none

module reorder_buffer #(
	parameter int ROB_DEPTH = 16
) (
	input  wire                     clock,
	input  wire                     arst_n,
	input  wire ooo_pkg::dispatch_t disp,
	input  wire ooo_pkg::cdb_t      cdb,
	output logic                    rob_ready,
	output ooo_pkg::rob_idx_t       rob_tail,
	output logic                    commit_valid,
	output ooo_pkg::ar_idx_t        commit_ar,
	output ooo_pkg::word_t          commit_data,
	input  wire                     commit_ready,
	output logic                    free_valid,
	output ooo_pkg::pr_tag_t        free_tag
);

	localparam ooo_pkg::rob_idx_t LAST_IDX = ooo_pkg::rob_idx_t'(ROB_DEPTH - 1);
	localparam logic [ooo_pkg::ROB_BITS:0] FULL = (ooo_pkg::ROB_BITS + 1)'(ROB_DEPTH);

	ooo_pkg::ar_idx_t          dest_ar_q [ROB_DEPTH];
	ooo_pkg::pr_tag_t          old_tag_q [ROB_DEPTH];
	ooo_pkg::word_t            value_q [ROB_DEPTH];
	logic [ROB_DEPTH-1:0]      done_q;
	ooo_pkg::rob_idx_t         head_q;
	ooo_pkg::rob_idx_t         tail_q;
	logic [ooo_pkg::ROB_BITS:0] count_q;

	function automatic ooo_pkg::rob_idx_t next_idx(input ooo_pkg::rob_idx_t idx);
		return (idx == LAST_IDX) ? '0 : idx + 1'b1;
	endfunction

	assign rob_ready    = count_q != FULL;
	assign rob_tail     = tail_q;
	assign commit_valid = (count_q != '0) && done_q[head_q];
	assign commit_ar    = dest_ar_q[head_q];
	assign commit_data  = value_q[head_q];

	// A commit transfer also retires the previous mapping
	assign free_valid = commit_valid && commit_ready;
	assign free_tag   = old_tag_q[head_q];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			done_q  <= '0;
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (cdb.valid)
				done_q[cdb.rob_idx] <= 1'b1;
			if (disp.valid) begin
				done_q[tail_q] <= 1'b0;
				tail_q         <= next_idx(tail_q);
			end
			if (free_valid)
				head_q <= next_idx(head_q);
			case ({disp.valid, free_valid})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (disp.valid) begin
			dest_ar_q[tail_q] <= disp.dest_ar;
			old_tag_q[tail_q] <= disp.old_dest;
		end
		if (cdb.valid)
			value_q[cdb.rob_idx] <= cdb.value;
	end

endmodule

`default_nettype wire

/* ooo_core.sv */
`default_nettype none

module ooo_core #(
	parameter int ROB_DEPTH   = 16,
	parameter int IQ_DEPTH    = 8,
	parameter int MUL_LATENCY = 3    // At least 2
) (
	input  wire                       clock,
	input  wire                       arst_n,
	input  wire                       in_valid,
	input  wire ooo_pkg::decoded_op_t in_op,
	output logic                      in_ready,
	output logic                      commit_valid,
	output ooo_pkg::ar_idx_t          commit_ar,
	output ooo_pkg::word_t            commit_data,
	input  wire                       commit_ready
);

	ooo_pkg::dispatch_t disp;
	ooo_pkg::issue_t    iss;
	ooo_pkg::cdb_t      cdb;
	ooo_pkg::rob_idx_t  rob_tail;
	ooo_pkg::pr_tag_t   free_tag;
	ooo_pkg::word_t     opa;
	ooo_pkg::word_t     opb;
	logic               rob_ready;
	logic               iq_ready;
	logic               alu_ready;
	logic               mul_ready;
	logic               free_valid;

	rename_unit rename0 (
		.clock      (clock),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.in_ready   (in_ready),
		.rob_ready  (rob_ready),
		.iq_ready   (iq_ready),
		.rob_tail   (rob_tail),
		.free_valid (free_valid),
		.free_tag   (free_tag),
		.cdb        (cdb),
		.disp       (disp)
	);

	issue_queue #(.IQ_DEPTH(IQ_DEPTH)) iq0 (
		.clock     (clock),
		.arst_n    (arst_n),
		.disp      (disp),
		.cdb       (cdb),
		.alu_ready (alu_ready),
		.mul_ready (mul_ready),
		.iq_ready  (iq_ready),
		.iss       (iss)
	);

	phys_regfile prf0 (
		.clock     (clock),
		.arst_n    (arst_n),
		.rd_a_tag  (iss.src_a),
		.rd_b_tag  (iss.src_b),
		.rd_a_data (opa),
		.rd_b_data (opb),
		.cdb       (cdb)
	);

	exec_unit #(.MUL_LATENCY(MUL_LATENCY)) exu0 (
		.clock     (clock),
		.arst_n    (arst_n),
		.iss       (iss),
		.opa       (opa),
		.opb       (opb),
		.alu_ready (alu_ready),
		.mul_ready (mul_ready),
		.cdb       (cdb)
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob0 (
		.clock        (clock),
		.arst_n       (arst_n),
		.disp         (disp),
		.cdb          (cdb),
		.rob_ready    (rob_ready),
		.rob_tail     (rob_tail),
		.commit_valid (commit_valid),
		.commit_ar    (commit_ar),
		.commit_data  (commit_data),
		.commit_ready (commit_ready),
		.free_valid   (free_valid),
		.free_tag     (free_tag)
	);

endmodule

`default_nettype wire

/* ooo_core_props.sv */
`default_nettype none

module ooo_core_props (
	input wire                   clock,
	input wire                   arst_n,
	input wire                   commit_valid,
	input wire ooo_pkg::ar_idx_t commit_ar,
	input wire ooo_pkg::word_t   commit_data,
	input wire                   commit_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;   // Count of failed assertions

	// Stalled commit keeps its payload
	hold_commit: assert property (@(posedge clock) disable iff (!arst_n)
		commit_valid && !commit_ready |=>
			commit_valid && $stable(commit_ar) && $stable(commit_data))
		else begin
			fail_count++;
			$error("commit output changed while commit_ready was low");
		end

	known_commit_valid: assert property (@(posedge clock) disable iff (!arst_n)
		!$isunknown(commit_valid))
		else begin
			fail_count++;
			$error("commit_valid is unknown after reset");
		end

endmodule

`default_nettype wire

/* ooo_core_tb.sv */
`default_nettype none

module ooo_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROB_DEPTH    = 16;
	localparam int IQ_DEPTH     = 8;
	localparam int MUL_LATENCY  = 3;
	localparam int N_INSTR      = 200;
	localparam int RESET_CYCLES = 5;
	localparam int LONG_STALL   = 60;
	localparam int CYCLE_LIMIT  = N_INSTR * (MUL_LATENCY + 20) + RESET_CYCLES;

	logic                 clock;
	logic                 arst_n;
	logic                 in_valid;
	ooo_pkg::decoded_op_t in_op;
	logic                 in_ready;
	logic                 commit_valid;
	ooo_pkg::ar_idx_t     commit_ar;
	ooo_pkg::word_t       commit_data;
	logic                 commit_ready;

	ooo_pkg::decoded_op_t prog [N_INSTR];
	ooo_pkg::word_t       shadow [ooo_pkg::NUM_AR];   // Architectural state in program order
	ooo_pkg::ar_idx_t     exp_ar_q [$];
	ooo_pkg::word_t       exp_data_q [$];

	int   acc_cnt    = 0;
	int   commit_cnt = 0;
	int   err_value  = 0;
	int   err_other  = 0;
	int   cycle_cnt  = 0;
	logic in_fire       = 1'b0;
	logic in_long_stall = 1'b0;
	logic saw_full      = 1'b0;

	ooo_core #(
		.ROB_DEPTH   (ROB_DEPTH),
		.IQ_DEPTH    (IQ_DEPTH),
		.MUL_LATENCY (MUL_LATENCY)
	) ooo_core_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.in_op        (in_op),
		.in_ready     (in_ready),
		.commit_valid (commit_valid),
		.commit_ar    (commit_ar),
		.commit_data  (commit_data),
		.commit_ready (commit_ready)
	);

	bind ooo_core ooo_core_props props_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.commit_valid (commit_valid),
		.commit_ar    (commit_ar),
		.commit_data  (commit_data),
		.commit_ready (commit_ready)
	);

	always #20 clock = ~clock;

	function automatic ooo_pkg::word_t calc_result(input ooo_pkg::opcode_e op,
			input ooo_pkg::word_t a, input ooo_pkg::word_t b, input ooo_pkg::word_t imm);
		case (op)
			ooo_pkg::OP_ADD:  return a + b;
			ooo_pkg::OP_SUB:  return a - b;
			ooo_pkg::OP_AND:  return a & b;
			ooo_pkg::OP_XOR:  return a ^ b;
			ooo_pkg::OP_ADDI: return a + imm;
			ooo_pkg::OP_MUL:  return a * b;   // Lower 32 bits
			default:          return '0;
		endcase
	endfunction

	// Mostly r1..r6 so that dependences are frequent
	function automatic ooo_pkg::ar_idx_t pick_reg();
		if ($urandom % 4 != 0)
			return ooo_pkg::ar_idx_t'(1 + $urandom % 6);
		return ooo_pkg::ar_idx_t'($urandom % 32);
	endfunction

	function automatic ooo_pkg::decoded_op_t make_op(input ooo_pkg::opcode_e op,
			input int d, input int a, input int b, input ooo_pkg::word_t imm);
		ooo_pkg::decoded_op_t o;
		o.opcode = op;
		o.dest   = ooo_pkg::ar_idx_t'(d);
		o.src_a  = ooo_pkg::ar_idx_t'(a);
		o.src_b  = ooo_pkg::ar_idx_t'(b);
		o.imm    = imm;
		return o;
	endfunction

	task automatic build_program();
		ooo_pkg::opcode_e op;
		ooo_pkg::word_t   imm;
		prog[0] = make_op(ooo_pkg::OP_ADD, 10, 20, 21, '0);             // Unwritten sources
		prog[1] = make_op(ooo_pkg::OP_ADDI, 1, 0, 0, 32'h7fff_ffff);
		prog[2] = make_op(ooo_pkg::OP_ADDI, 2, 0, 0, 32'hffff_fff3);
		prog[3] = make_op(ooo_pkg::OP_ADD, 3, 1, 1, '0);                // Wraps
		prog[4] = make_op(ooo_pkg::OP_SUB, 4, 10, 1, '0);               // Borrows
		prog[5] = make_op(ooo_pkg::OP_MUL, 5, 1, 2, '0);
		prog[6] = make_op(ooo_pkg::OP_ADD, 6, 5, 1, '0);                // Needs the product
		prog[7] = make_op(ooo_pkg::OP_MUL, 6, 6, 6, '0);
		prog[8] = make_op(ooo_pkg::OP_XOR, 6, 6, 2, '0);
		prog[9] = make_op(ooo_pkg::OP_AND, 7, 6, 3, '0);
		for (int i = 10; i < N_INSTR; i++) begin
			op  = ooo_pkg::opcode_e'(3'($urandom % 6));
			imm = ($urandom % 2 != 0) ? ooo_pkg::word_t'($urandom)
				: ooo_pkg::word_t'($urandom % 16);
			prog[i] = make_op(op, pick_reg(), pick_reg(), pick_reg(), imm);
		end
	endtask

	task automatic report_and_stop();
		$display("Errors: %0d wrong value, %0d other; %0d of %0d commits",
			err_value, err_other, commit_cnt, N_INSTR);
		if (err_value + err_other == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	// Accepted instructions set the expected commit stream
	always @(negedge clock) begin
		ooo_pkg::word_t res;
		in_fire = arst_n && in_valid && in_ready;
		if (in_fire) begin
			res = calc_result(in_op.opcode, shadow[in_op.src_a], shadow[in_op.src_b], in_op.imm);
			shadow[in_op.dest] = res;
			exp_ar_q.push_back(in_op.dest);
			exp_data_q.push_back(res);
			acc_cnt++;
		end
		if (in_long_stall && !in_ready)
			saw_full = 1'b1;
	end

	// Commit compare
	always @(negedge clock) begin
		ooo_pkg::ar_idx_t exp_ar;
		ooo_pkg::word_t   exp_data;
		if (arst_n && commit_valid && commit_ready) begin
			assert (exp_ar_q.size() > 0) else begin
				err_other++;
				$display("A commit arrived with no instruction left to commit");
			end
			if (exp_ar_q.size() > 0) begin
				exp_ar   = exp_ar_q.pop_front();
				exp_data = exp_data_q.pop_front();
				assert (commit_ar == exp_ar) else begin
					err_value++;
					$display("ERR commit_ar: got %h, expected %h (commit %0d)",
						commit_ar, exp_ar, commit_cnt);
				end
				assert (commit_data == exp_data) else begin
					err_value++;
					$display("ERR commit_data: got %h, expected %h (commit %0d)",
						commit_data, exp_data, commit_cnt);
				end
			end
			commit_cnt++;
		end
	end

	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		err_other++;
		report_and_stop();
	end

	initial begin
		int  idx;
		int  stall_left;
		logic long_done;
		logic hold;
		void'($urandom(39));
		clock        = 1'b0;
		arst_n       = 1'b0;
		in_valid     = 1'b0;
		in_op        = '0;
		commit_ready = 1'b0;
		idx          = 0;
		stall_left   = 0;
		long_done    = 1'b0;
		for (int r = 0; r < ooo_pkg::NUM_AR; r++) begin
			shadow[r] = '0;
		end
		build_program();
		repeat (RESET_CYCLES) @(posedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		assert (!commit_valid && in_ready) else begin
			err_other++;
			$display("After reset commit_valid should be low and in_ready high");
		end
		while (commit_cnt < N_INSTR) begin
			@(posedge clock);
			hold = in_valid && !in_fire;   // Offered but not yet taken
			if (in_fire)
				idx++;
			if (idx >= N_INSTR) begin
				in_valid <= 1'b0;
			end else if (hold || $urandom % 4 != 0) begin
				in_valid <= 1'b1;
				in_op    <= prog[idx];
			end else begin
				in_valid <= 1'b0;
			end
			if (!long_done && acc_cnt >= 80) begin
				stall_left    = LONG_STALL;
				long_done     = 1'b1;
				in_long_stall = 1'b1;
			end
			if (stall_left > 0) begin
				commit_ready <= 1'b0;
				stall_left--;
			end else begin
				in_long_stall = 1'b0;
				if ($urandom % 10 == 0) begin
					stall_left = $urandom % 5;
					commit_ready <= 1'b0;
				end else begin
					commit_ready <= 1'b1;
				end
			end
		end
		repeat (10) @(posedge clock);
		assert (exp_ar_q.size() == 0 && commit_cnt == N_INSTR) else begin
			err_other++;
			$display("Commit count is wrong, %0d instructions still expected", exp_ar_q.size());
		end
		assert (saw_full) else begin
			err_other++;
			$display("in_ready never fell during the long commit stall");
		end
		err_other += ooo_core_i.props_i.fail_count;
		report_and_stop();
	end

endmodule

`default_nettype wire

/* sources.f */
ooo_pkg.sv
rename_unit.sv
issue_queue.sv
phys_regfile.sv
exec_unit.sv
reorder_buffer.sv
ooo_core.sv
ooo_core_props.sv
ooo_core_tb.sv
